// File: source/fetch_cfg.svh
/*
 * fetch front end sizing
 * word-addressed pc width, memory depth and trap vector reset value
 */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// pc and host address width in words
`define FETCH_ADR_W 30
// instruction memory, indexed by low pc bits
`define FETCH_MEM_DEPTH 256
`define FETCH_MEM_AW 8
// mtvec after reset, word address
`define FETCH_MTVEC_RST 30'h0000_0040

`endif

// File: source/rv_isa_pkg.sv
/*
 * RV32I instruction formats
 * one word seen as J-type or as SYSTEM, plus the opcodes the front end decodes
 */
`default_nettype none

package rv_isa_pkg;

	// jal immediate fields in encoding order
	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_jtype_s;

	// ecall, mret, sret all live under SYSTEM
	typedef struct packed {
		logic [11:0] funct12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_system_s;

	typedef union packed {
		rv_jtype_s  j;
		rv_system_s sys;
	} rv_instr_u;

	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// funct12 of the privileged system ops
	localparam logic [11:0] F12_ECALL = 12'h000;
	localparam logic [11:0] F12_MRET = 12'h302;
	localparam logic [11:0] F12_SRET = 12'h102;

endpackage

`default_nettype wire

// File: source/fetch_pkg.sv
/*
 * fetch machinery types
 * sequencer states and memory port owner
 */
`default_nettype none

package fetch_pkg;

	// idle until start, then request / execute loop
	typedef enum logic [1:0] {
		FS_IDLE,
		FS_REQ,
		FS_EXE
	} fetch_state_e;

	// who drives the single memory port
	typedef enum logic {
		OWN_HOST,
		OWN_FETCH
	} arb_owner_e;

endpackage

`default_nettype wire

// File: source/pc_stage.sv
/*
 * program counter stage
 * start load, trap / return / jal redirect, increment, exception pc capture
 */
`default_nettype none
`include "fetch_cfg.svh"

module pc_stage (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     cpu_start,
	input  wire                     cpu_stat_pc,
	input  wire                     ecall_condition_ex,
	input  wire                     g_interrupt,
	input  wire                     g_exception,
	input  wire                     jmp_condition_ex,
	input  wire                     cmd_mret_ex,
	input  wire                     cmd_sret_ex,
	input  wire [`FETCH_ADR_W-1:0] cpu_start_adr,
	input  wire [`FETCH_ADR_W-1:0] csr_mtvec_ex,
	input  wire [`FETCH_ADR_W-1:0] csr_mepc_ex,
	input  wire [`FETCH_ADR_W-1:0] csr_sepc_ex,
	input  wire [`FETCH_ADR_W-1:0] jmp_adr_ex,
	output logic [`FETCH_ADR_W-1:0] pc,
	output logic [`FETCH_ADR_W-1:0] pc_excep
);

	logic                    trap;
	logic                    redirect;
	logic [`FETCH_ADR_W-1:0] redirect_adr;
	logic                    cpu_adr_ld;

	// any trap source goes to mtvec
	assign trap = ecall_condition_ex | g_interrupt | g_exception;
	assign redirect = trap | jmp_condition_ex | cmd_mret_ex | cmd_sret_ex;

	// trap beats return, return beats jal
	assign redirect_adr = trap ? csr_mtvec_ex :
		cmd_mret_ex ? csr_mepc_ex :
		cmd_sret_ex ? csr_sepc_ex : jmp_adr_ex;

	// start pending until the first stat pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cpu_adr_ld <= 1'b0;
		else if (cpu_stat_pc)
			cpu_adr_ld <= 1'b0;
		else if (cpu_start)
			cpu_adr_ld <= 1'b1;
	end

	// pc only moves on the edge that ends a stat pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (cpu_stat_pc & cpu_adr_ld)
			pc <= cpu_start_adr;
		else if (cpu_stat_pc & redirect)
			pc <= redirect_adr;
		else if (cpu_stat_pc)
			pc <= pc + 1'b1;
	end

	// faulting pc, read back as mepc
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc_excep <= '0;
		else if (cpu_stat_pc & trap)
			pc_excep <= pc;
	end

endmodule

`default_nettype wire

// File: source/fetch_ctrl.sv
/*
 * fetch sequencer
 * requests the word at pc, captures it, and pulses cpu_stat_pc once per word
 */
`default_nettype none

module fetch_ctrl (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               cpu_start,
	input  wire               fetch_gnt,
	input  wire [31:0]        mem_rdata,
	output logic              fetch_req,
	output rv_isa_pkg::rv_instr_u instr,
	output logic              cpu_stat_pc
);

	import fetch_pkg::*;

	fetch_state_e state;

	// level request, dropped on the granting edge
	assign fetch_req = (state == FS_REQ);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FS_IDLE;
			cpu_stat_pc <= 1'b0;
		end else begin
			case (state)
				// start pulse carries no instruction, only loads pc
				FS_IDLE: if (cpu_start) begin
					state <= FS_EXE;
					cpu_stat_pc <= 1'b1;
				end
				FS_REQ: if (fetch_gnt)
					state <= FS_EXE;
				// first cycle data valid, second cycle is the pulse
				FS_EXE: if (cpu_stat_pc) begin
					state <= FS_REQ;
					cpu_stat_pc <= 1'b0;
				end else begin
					cpu_stat_pc <= 1'b1;
				end
				default: state <= FS_IDLE;
			endcase
		end
	end

	// instruction word, no-op on the start pulse
	always_ff @(posedge clk) begin
		if (state == FS_IDLE && cpu_start)
			instr <= '0;
		else if (state == FS_EXE && !cpu_stat_pc)
			instr <= mem_rdata;
	end

endmodule

`default_nettype wire

// File: source/redirect_unit.sv
/*
 * control-flow decode
 * jal target, ecall / mret / sret, illegal opcode trap,
 * host-written mtvec and sepc
 */
`default_nettype none
`include "fetch_cfg.svh"

module redirect_unit (
	input  wire                     clk,
	input  wire                     rst_n,
	input  rv_isa_pkg::rv_instr_u   instr,
	input  wire [`FETCH_ADR_W-1:0] pc,
	input  wire                     host_csr_we,
	input  wire                     host_csr_sel,
	input  wire [`FETCH_ADR_W-1:0] host_adr,
	output logic                    jmp_condition_ex,
	output logic [`FETCH_ADR_W-1:0] jmp_adr_ex,
	output logic                    ecall_condition_ex,
	output logic                    g_exception,
	output logic                    cmd_mret_ex,
	output logic                    cmd_sret_ex,
	output logic [`FETCH_ADR_W-1:0] csr_mtvec_ex,
	output logic [`FETCH_ADR_W-1:0] csr_sepc_ex
);

	import rv_isa_pkg::*;

	logic                    is_jal;
	logic                    is_sys;
	logic                    is_nop;
	logic                    sys_bad;
	logic [`FETCH_ADR_W-1:0] jal_ofs;

	assign is_jal = (instr.j.opcode == OPC_JAL);
	assign is_sys = (instr.sys.opcode == OPC_SYSTEM);
	// all-zero word fills unused memory
	assign is_nop = (instr.sys.opcode == 7'b0000000);

	// byte offset bits 20:2, the word offset
	assign jal_ofs = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
		instr.j.imm_11, instr.j.imm_10_1[9:1]};

	assign jmp_condition_ex = is_jal;
	assign jmp_adr_ex = pc + jal_ofs;

	// system view
	assign ecall_condition_ex = is_sys & (instr.sys.funct12 == F12_ECALL);
	assign cmd_mret_ex = is_sys & (instr.sys.funct12 == F12_MRET);
	assign cmd_sret_ex = is_sys & (instr.sys.funct12 == F12_SRET);
	assign sys_bad = is_sys & ~(ecall_condition_ex | cmd_mret_ex | cmd_sret_ex);

	// unknown opcode or unknown system function
	assign g_exception = ~(is_jal | is_sys | is_nop) | sys_bad;

	// sel 0 is mtvec, sel 1 is sepc
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csr_mtvec_ex <= `FETCH_MTVEC_RST;
			csr_sepc_ex <= '0;
		end else if (host_csr_we) begin
			if (host_csr_sel)
				csr_sepc_ex <= host_adr;
			else
				csr_mtvec_ex <= host_adr;
		end
	end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
/*
 * instruction memory arbiter
 * host writes first, fetch reads otherwise, one outstanding read
 */
`default_nettype none
`include "fetch_cfg.svh"

module mem_arbiter (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     host_we,
	input  wire [`FETCH_ADR_W-1:0] host_adr,
	input  wire [31:0]              host_wdata,
	input  wire                     fetch_req,
	input  wire [`FETCH_ADR_W-1:0] fetch_adr,
	output logic                    fetch_gnt,
	output logic                    mem_we,
	output logic [`FETCH_MEM_AW-1:0] mem_adr,
	output logic [31:0]             mem_wdata
);

	import fetch_pkg::*;

	arb_owner_e owner;
	arb_owner_e owner_q;

	// host strobe takes the port outright
	assign owner = host_we ? OWN_HOST : OWN_FETCH;

	// no new read grant while the last one returns data
	assign fetch_gnt = fetch_req & (owner == OWN_FETCH) & (owner_q != OWN_FETCH);

	assign mem_we = host_we;
	assign mem_wdata = host_wdata;
	assign mem_adr = (owner == OWN_HOST) ? host_adr[`FETCH_MEM_AW-1:0] :
		fetch_adr[`FETCH_MEM_AW-1:0];

	// fetch owner only in the cycle after a granted read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			owner_q <= OWN_HOST;
		else
			owner_q <= fetch_gnt ? OWN_FETCH : OWN_HOST;
	end

endmodule

`default_nettype wire

// File: source/inst_mem.sv
/*
 * instruction memory
 * single port, word wide, registered read
 */
`default_nettype none
`include "fetch_cfg.svh"

module inst_mem (
	input  wire                      clk,
	input  wire                      mem_we,
	input  wire [`FETCH_MEM_AW-1:0] mem_adr,
	input  wire [31:0]               mem_wdata,
	output logic [31:0]              mem_rdata
);

	logic [31:0] mem [0:`FETCH_MEM_DEPTH-1];

	// read returns old data on a write cycle
	always_ff @(posedge clk) begin
		if (mem_we)
			mem[mem_adr] <= mem_wdata;
		mem_rdata <= mem[mem_adr];
	end

endmodule

`default_nettype wire

// File: source/fetch_top.sv
/*
 * fetch front end top
 * pc stage, sequencer and decode sharing one memory with the host loader
 */
`default_nettype none
`include "fetch_cfg.svh"

module fetch_top (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     cpu_start,
	input  wire [`FETCH_ADR_W-1:0] cpu_start_adr,
	input  wire                     g_interrupt,
	input  wire                     host_we,
	input  wire [`FETCH_ADR_W-1:0] host_adr,
	input  wire [31:0]              host_wdata,
	input  wire                     host_csr_we,
	input  wire                     host_csr_sel,
	output logic [`FETCH_ADR_W-1:0] pc,
	output logic [`FETCH_ADR_W-1:0] pc_excep,
	output rv_isa_pkg::rv_instr_u   instr,
	output logic                    instr_valid
);

	logic                     cpu_stat_pc;
	logic                     fetch_req;
	logic                     fetch_gnt;
	logic                     mem_we;
	logic [`FETCH_MEM_AW-1:0] mem_adr;
	logic [31:0]              mem_wdata;
	logic [31:0]              mem_rdata;
	logic                     jmp_condition_ex;
	logic [`FETCH_ADR_W-1:0]  jmp_adr_ex;
	logic                     ecall_condition_ex;
	logic                     g_exception;
	logic                     cmd_mret_ex;
	logic                     cmd_sret_ex;
	logic [`FETCH_ADR_W-1:0]  csr_mtvec_ex;
	logic [`FETCH_ADR_W-1:0]  csr_sepc_ex;

	// retire strobe seen outside
	assign instr_valid = cpu_stat_pc;

	pc_stage u_pc_stage (
		.clk, .rst_n, .cpu_start, .cpu_stat_pc, .ecall_condition_ex, .g_interrupt,
		.g_exception, .jmp_condition_ex, .cmd_mret_ex, .cmd_sret_ex, .cpu_start_adr,
		.csr_mtvec_ex, .csr_mepc_ex(pc_excep), .csr_sepc_ex, .jmp_adr_ex, .pc, .pc_excep
	);

	fetch_ctrl u_fetch_ctrl (
		.clk, .rst_n, .cpu_start, .fetch_gnt, .mem_rdata, .fetch_req, .instr, .cpu_stat_pc
	);

	redirect_unit u_redirect_unit (
		.clk, .rst_n, .instr, .pc, .host_csr_we, .host_csr_sel, .host_adr,
		.jmp_condition_ex, .jmp_adr_ex, .ecall_condition_ex, .g_exception,
		.cmd_mret_ex, .cmd_sret_ex, .csr_mtvec_ex, .csr_sepc_ex
	);

	// fetcher reads at the current pc
	mem_arbiter u_mem_arbiter (
		.clk, .rst_n, .host_we, .host_adr, .host_wdata, .fetch_req, .fetch_adr(pc),
		.fetch_gnt, .mem_we, .mem_adr, .mem_wdata
	);

	inst_mem u_inst_mem (
		.clk, .mem_we, .mem_adr, .mem_wdata, .mem_rdata
	);

endmodule

`default_nettype wire

// File: verif/fetch_top_assertions.sv
/*
 * fetch sequencer protocol checks
 * bound into fetch_ctrl, watches the stat pulse and the memory request
 */
`default_nettype none

module fetch_top_assertions (
	input wire       clk,
	input wire       rst_n,
	input wire       cpu_stat_pc,
	input wire       fetch_req,
	input wire       fetch_gnt,
	input wire [1:0] state
);

	import fetch_pkg::*;

	// retire strobe never stretches
	stat_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_stat_pc |=> !cpu_stat_pc)
		else $error("cpu_stat_pc held for more than one cycle");

	// request is a level until the arbiter grants it
	req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(fetch_req && !fetch_gnt) |=> fetch_req)
		else $error("fetch_req dropped before fetch_gnt");

	// idle sequencer retires nothing
	no_idle_stat: assert property (@(posedge clk) disable iff (!rst_n)
		(state == FS_IDLE) |-> !cpu_stat_pc)
		else $error("cpu_stat_pc seen in FS_IDLE");

endmodule

bind fetch_ctrl fetch_top_assertions u_fetch_top_assertions (
	.clk, .rst_n, .cpu_stat_pc, .fetch_req, .fetch_gnt, .state
);

`default_nettype wire

// File: verif/fetch_top_tb.sv
/*
 * fetch front end testbench
 * directed tests for sequential fetch, jal, traps, returns and host contention
 */
`default_nettype none
`include "fetch_cfg.svh"

module fetch_top_tb;

	import rv_isa_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS = 5;
	// memory fill plus a generous per-test budget, doubled
	localparam int FILL_CYCLES = `FETCH_MEM_DEPTH + 4;
	localparam int TEST_CYCLES = 120;
	localparam int WATCHDOG_TIME = 2 * CLK_PERIOD * (FILL_CYCLES + NUM_TESTS * TEST_CYCLES);
	// request, data return, retire pulse
	localparam int RETIRE_CYCLES = 3;

	logic                    clk;
	logic                    rst_n;
	logic                    cpu_start;
	logic [`FETCH_ADR_W-1:0] cpu_start_adr;
	logic                    g_interrupt;
	logic                    host_we;
	logic [`FETCH_ADR_W-1:0] host_adr;
	logic [31:0]             host_wdata;
	logic                    host_csr_we;
	logic                    host_csr_sel;
	logic [`FETCH_ADR_W-1:0] pc;
	logic [`FETCH_ADR_W-1:0] pc_excep;
	rv_instr_u               instr;
	logic                    instr_valid;

	// expected memory contents, kept in step with every host write
	logic [31:0] ref_mem [0:`FETCH_MEM_DEPTH-1];
	logic [31:0] lcg_state;
	int          cycle_cnt;

	fetch_top u_fetch_top (
		.clk, .rst_n, .cpu_start, .cpu_start_adr, .g_interrupt, .host_we, .host_adr,
		.host_wdata, .host_csr_we, .host_csr_sel, .pc, .pc_excep, .instr, .instr_valid
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// free cycle count for retire spacing
	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// opcode zero decodes as no-op, upper bits vary with address
	function automatic logic [31:0] fill_word(input logic [`FETCH_ADR_W-1:0] adr);
		logic [31:0] r;
		r = lcg_next() ^ {4{adr[7:0]}};
		return {r[31:7], 7'b0000000};
	endfunction

	// byte offset into the J-type immediate fields
	function automatic logic [31:0] make_jal(input int byte_ofs);
		rv_instr_u   w;
		logic [20:0] imm;
		imm = byte_ofs[20:0];
		w.j.imm_20 = imm[20];
		w.j.imm_10_1 = imm[10:1];
		w.j.imm_11 = imm[11];
		w.j.imm_19_12 = imm[19:12];
		w.j.rd = 5'd0;
		w.j.opcode = OPC_JAL;
		return w;
	endfunction

	function automatic logic [31:0] make_sys(input logic [11:0] f12);
		rv_instr_u w;
		w.sys.funct12 = f12;
		w.sys.rs1 = 5'd0;
		w.sys.funct3 = 3'd0;
		w.sys.rd = 5'd0;
		w.sys.opcode = OPC_SYSTEM;
		return w;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// leaves host_we high so writes can run back to back
	task automatic load_word(input logic [`FETCH_ADR_W-1:0] adr, input logic [31:0] data);
		@(posedge clk);
		#2;
		host_we = 1'b1;
		host_adr = adr;
		host_wdata = data;
		ref_mem[adr[`FETCH_MEM_AW-1:0]] = data;
	endtask

	task automatic host_idle();
		@(posedge clk);
		#2;
		host_we = 1'b0;
	endtask

	// sel 0 mtvec, sel 1 sepc
	task automatic write_csr(input logic sel, input logic [`FETCH_ADR_W-1:0] value);
		@(posedge clk);
		#2;
		host_csr_we = 1'b1;
		host_csr_sel = sel;
		host_adr = value;
		@(posedge clk);
		#2;
		host_csr_we = 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
	endtask

	// returns at the falling edge inside the retire cycle
	task automatic wait_valid();
		@(negedge clk);
		while (!instr_valid)
			@(negedge clk);
	endtask

	task automatic expect_fetch(input logic [`FETCH_ADR_W-1:0] exp_pc);
		wait_valid();
		check("pc", {2'b00, pc}, {2'b00, exp_pc});
		check("instr", instr, ref_mem[exp_pc[`FETCH_MEM_AW-1:0]]);
	endtask

	// first pulse only loads the start address, pc still at reset value
	task automatic start_core(input logic [`FETCH_ADR_W-1:0] adr);
		@(posedge clk);
		#2;
		cpu_start_adr = adr;
		cpu_start = 1'b1;
		@(posedge clk);
		#2;
		cpu_start = 1'b0;
		wait_valid();
		check("instr", instr, 32'h0);
		check("pc", {2'b00, pc}, 32'h0);
	endtask

	task automatic fill_memory();
		for (int a = 0; a < `FETCH_MEM_DEPTH; a++)
			load_word(30'(a), fill_word(30'(a)));
		host_idle();
	endtask

	task automatic sequential_fetch();
		logic [`FETCH_ADR_W-1:0] start;
		start = 30'h10;
		apply_reset();
		start_core(start);
		for (int k = 0; k < 8; k++)
			expect_fetch(start + 30'(k));
	endtask

	// forward 5 words, then back 4 words
	task automatic jal_redirect();
		logic [`FETCH_ADR_W-1:0] jpc;
		jpc = 30'h30;
		apply_reset();
		load_word(jpc, make_jal(20));
		load_word(jpc + 30'd5, make_jal(-16));
		host_idle();
		start_core(jpc);
		expect_fetch(jpc);
		expect_fetch(jpc + 30'd5);
		expect_fetch(jpc + 30'd1);
	endtask

	task automatic ecall_mret_return();
		logic [`FETCH_ADR_W-1:0] epc;
		epc = 30'h50;
		apply_reset();
		load_word(epc, make_sys(F12_ECALL));
		load_word(`FETCH_MTVEC_RST, make_sys(F12_MRET));
		host_idle();
		start_core(epc);
		expect_fetch(epc);
		expect_fetch(`FETCH_MTVEC_RST);
		check("pc_excep", {2'b00, pc_excep}, {2'b00, epc});
		expect_fetch(epc);
	endtask

	// addi opcode and wfi funct12 are both outside the decoded set
	task automatic sret_illegal_trap();
		logic [`FETCH_ADR_W-1:0] spc;
		logic [`FETCH_ADR_W-1:0] sepc;
		logic [`FETCH_ADR_W-1:0] tvec;
		spc = 30'h58;
		sepc = 30'h70;
		tvec = 30'h48;
		apply_reset();
		write_csr(1'b1, sepc);
		write_csr(1'b0, tvec);
		load_word(spc, make_sys(F12_SRET));
		load_word(sepc, 32'h0000_0013);
		load_word(tvec, make_sys(12'h105));
		host_idle();
		start_core(spc);
		expect_fetch(spc);
		expect_fetch(sepc);
		expect_fetch(tvec);
		check("pc_excep", {2'b00, pc_excep}, {2'b00, sepc});
		expect_fetch(tvec);
		check("pc_excep", {2'b00, pc_excep}, {2'b00, tvec});
	endtask

	task automatic interrupt_contention();
		logic [`FETCH_ADR_W-1:0] ipc;
		logic [`FETCH_ADR_W-1:0] cpc;
		int                      t_prev;
		ipc = 30'h80;
		cpc = 30'h90;
		apply_reset();
		start_core(ipc);
		expect_fetch(ipc);
		// interrupt spans the whole next retire
		@(posedge clk);
		#2;
		g_interrupt = 1'b1;
		expect_fetch(ipc + 30'd1);
		@(posedge clk);
		#2;
		g_interrupt = 1'b0;
		expect_fetch(`FETCH_MTVEC_RST);
		check("pc_excep", {2'b00, pc_excep}, {2'b00, ipc + 30'd1});
		// uncontended spacing first, then k host writes per gap
		apply_reset();
		start_core(cpc);
		expect_fetch(cpc);
		t_prev = cycle_cnt;
		expect_fetch(cpc + 30'd1);
		check("retire_gap", 32'(cycle_cnt - t_prev), 32'(RETIRE_CYCLES));
		for (int k = 1; k <= 3; k++) begin
			t_prev = cycle_cnt;
			for (int w = 0; w < k; w++)
				load_word(30'hc0 + 30'(w + 4 * k), fill_word(30'hc0 + 30'(w + 4 * k)));
			host_idle();
			expect_fetch(cpc + 30'(k + 1));
			check("retire_gap", 32'(cycle_cnt - t_prev), 32'(RETIRE_CYCLES + k));
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		cpu_start = 1'b0;
		cpu_start_adr = '0;
		g_interrupt = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_wdata = '0;
		host_csr_we = 1'b0;
		host_csr_sel = 1'b0;
		lcg_state = 32'h1100;
		cycle_cnt = 0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		fill_memory();
		sequential_fetch();
		jal_redirect();
		ecall_mret_return();
		sret_illegal_trap();
		interrupt_contention();
		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// File: fetch_top.f
+incdir+source
source/rv_isa_pkg.sv
source/fetch_pkg.sv
source/pc_stage.sv
source/fetch_ctrl.sv
source/redirect_unit.sv
source/mem_arbiter.sv
source/inst_mem.sv
source/fetch_top.sv
verif/fetch_top_assertions.sv
verif/fetch_top_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the fetch_top testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f fetch_top.f \
	--top-module fetch_top_tb -o sim_fetch_top
./obj_dir/sim_fetch_top > sim.log 2>&1 || true
cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
